//--- Bender.yml
package:
  name: memAlign

sources:
  - memAlignPkg.sv
  - tlbLookup.sv
  - accessAlign.sv
  - lineQueue.sv
  - lineStore.sv
  - memAlignTop.sv
  - target: test
    files:
      - memAlignTb_asserts.sv
      - memAlignTb.sv

//--- accessAlign.sv
module accessAlign (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  reqValid,
    input  memAlignPkg::memReqT   req,
    input  logic                  fill,
    input  logic [2:0]            fillIdx,
    input  memAlignPkg::tlbEntryT fillEntry,
    output memAlignPkg::lineAccT  acc0,
    output memAlignPkg::lineAccT  acc1,
    output logic                  accValid0,
    output logic                  accValid1,
    output logic                  fault,
    output logic                  faultMiss,
    output logic                  faultProt
);
    import memAlignPkg::*;

    logic [3:0]                  offset;
    logic [4:0]                  byteCnt;
    logic [4:0]                  endPos;
    logic                        split;
    byteMaskT                    sizeMask;
    logic [2*LINE_BYTES-1:0]     maskWide;
    logic [2*LINE_BYTES*8-1:0]   dataWide;
    vAddrT                       nextAddr;
    pfnT                         pfn0;
    pfnT                         pfn1;
    logic                        miss0;
    logic                        miss1;
    logic                        prot0;
    logic                        prot1;
    pAddrT                       pAddr0;
    pAddrT                       pAddr1;
    logic                        anyMiss;
    logic                        anyProt;
    logic                        anyFault;

    assign offset  = req.vAddr[3:0];
    assign byteCnt = 5'd1 << req.size;
    assign endPos  = {1'b0, offset} + byteCnt;
    assign split   = endPos > 5'(LINE_BYTES);

    always_comb begin
        case (req.size)
            SIZE_B1: sizeMask = 16'h0001;
            SIZE_B2: sizeMask = 16'h0003;
            SIZE_B4: sizeMask = 16'h000f;
            SIZE_B8: sizeMask = 16'h00ff;
            default: sizeMask = '0;
        endcase
    end

    // one shift across two lines, the upper half spills into the next line
    assign maskWide = {byteMaskT'('0), sizeMask} << offset;
    assign dataWide = {lineDataT'('0), req.data} << {offset, 3'b000};

    assign nextAddr = req.vAddr + vAddrT'(LINE_BYTES);

    tlbLookup tlbLine0 (
        .clk       (clk),
        .rstN      (rstN),
        .fill      (fill),
        .fillIdx   (fillIdx),
        .fillEntry (fillEntry),
        .vpn       (req.vAddr[31:12]),
        .write     (req.write),
        .pfn       (pfn0),
        .miss      (miss0),
        .prot      (prot0)
    );

    // second lookup for the following line
    tlbLookup tlbLine1 (
        .clk       (clk),
        .rstN      (rstN),
        .fill      (fill),
        .fillIdx   (fillIdx),
        .fillEntry (fillEntry),
        .vpn       (nextAddr[31:12]),
        .write     (req.write),
        .pfn       (pfn1),
        .miss      (miss1),
        .prot      (prot1)
    );

    assign pAddr0 = {pfn0, req.vAddr[11:0]};
    assign pAddr1 = {pfn1, nextAddr[11:0]};

    // second translation only counts when the access really splits
    assign anyMiss  = miss0 || (split && miss1);
    assign anyProt  = prot0 || (split && prot1);
    assign anyFault = anyMiss || anyProt;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            accValid0 <= 1'b0;
            accValid1 <= 1'b0;
            fault     <= 1'b0;
            faultMiss <= 1'b0;
            faultProt <= 1'b0;
        end else begin
            accValid0 <= reqValid && !anyFault;
            accValid1 <= reqValid && split && !anyFault;
            fault     <= reqValid && anyFault;
            // cause flags hold until the next request
            if (reqValid) begin
                faultMiss <= anyMiss;
                faultProt <= anyProt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid) begin
            acc0.line  <= pAddr0[14:4];
            acc0.write <= req.write;
            acc0.mask  <= maskWide[LINE_BYTES-1:0];
            acc0.data  <= dataWide[LINE_BYTES*8-1:0];
            acc1.line  <= pAddr1[14:4];
            acc1.write <= req.write;
            acc1.mask  <= maskWide[2*LINE_BYTES-1:LINE_BYTES];
            acc1.data  <= dataWide[2*LINE_BYTES*8-1:LINE_BYTES*8];
        end
    end

endmodule

//--- lineQueue.sv
module lineQueue #(
    parameter int DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 push0,
    input  logic                 push1,
    input  memAlignPkg::lineAccT in0,
    input  memAlignPkg::lineAccT in1,
    input  logic                 pop,
    output memAlignPkg::lineAccT head,
    output logic                 empty,
    output logic                 almostFull
);
    import memAlignPkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    lineAccT          mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0]   count;
    logic [1:0]       pushCnt;
    logic             popEn;

    assign pushCnt = {1'b0, push0} + {1'b0, push1};
    assign popEn   = pop && !empty;

    // in1 always lands right behind in0
    always_ff @(posedge clk) begin
        if (push0) begin
            mem[wrPtr] <= in0;
        end
        if (push1) begin
            mem[wrPtr + PTR_W'(1)] <= in1;
        end
    end

    // pointers wrap naturally since depth is a power of two
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            wrPtr <= wrPtr + PTR_W'(pushCnt);
            if (popEn) begin
                rdPtr <= rdPtr + PTR_W'(1);
            end
            count <= count + (PTR_W+1)'(pushCnt) - (PTR_W+1)'(popEn);
        end
    end

    assign head  = mem[rdPtr];
    assign empty = (count == '0);
    // fewer than four free slots
    assign almostFull = count > (PTR_W+1)'(DEPTH - 4);

endmodule

//--- lineStore.sv
module lineStore #(
    parameter int LINES = 16
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  empty,
    input  memAlignPkg::lineAccT  head,
    output logic                  pop,
    output logic                  rspValid,
    output memAlignPkg::lineIdxT  rspLine,
    output memAlignPkg::byteMaskT rspMask,
    output memAlignPkg::lineDataT rspData
);
    import memAlignPkg::*;

    localparam int IDX_W = $clog2(LINES);

    lineDataT         lines [LINES];
    logic [IDX_W-1:0] idx;
    lineDataT         bitMask;

    // drain one entry every cycle the queue has something
    assign pop = !empty;
    assign idx = IDX_W'(head.line % LINES);

    // widen byte enables to bit enables
    always_comb begin
        for (int k = 0; k < LINE_BYTES; k++) begin
            bitMask[8*k +: 8] = {8{head.mask[k]}};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < LINES; i++) begin
                lines[i] <= '0;
            end
        end else if (pop && head.write) begin
            // merge only the enabled bytes
            lines[idx] <= (lines[idx] & ~bitMask) | (head.data & bitMask);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rspValid <= 1'b0;
        end else begin
            rspValid <= pop && !head.write;
        end
    end

    // read response payload, bytes outside the mask read as zero
    always_ff @(posedge clk) begin
        if (pop && !head.write) begin
            rspLine <= head.line;
            rspMask <= head.mask;
            rspData <= lines[idx] & bitMask;
        end
    end

endmodule

//--- list.f
memAlignPkg.sv
tlbLookup.sv
accessAlign.sv
lineQueue.sv
lineStore.sv
memAlignTop.sv
memAlignTb_asserts.sv
memAlignTb.sv

//--- memAlignPkg.sv
package memAlignPkg;

    // line geometry and tlb size are fixed for the whole path
    localparam int LINE_BYTES  = 16;
    localparam int TLB_ENTRIES = 8;

    typedef logic [31:0]               vAddrT;
    // frame number in 14:12, page offset in 11:0
    typedef logic [14:0]               pAddrT;
    typedef logic [LINE_BYTES*8-1:0]   lineDataT;
    typedef logic [LINE_BYTES-1:0]     byteMaskT;
    typedef logic [19:0]               vpnT;
    typedef logic [2:0]                pfnT;
    // physical address bits 14:4
    typedef logic [10:0]               lineIdxT;
    typedef logic [1:0]                accSizeT;

    // access size codes
    localparam accSizeT SIZE_B1 = 2'd0;
    localparam accSizeT SIZE_B2 = 2'd1;
    localparam accSizeT SIZE_B4 = 2'd2;
    localparam accSizeT SIZE_B8 = 2'd3;

    typedef struct packed {
        vpnT  vpn;
        pfnT  pfn;
        logic valid;
        logic writable;
    } tlbEntryT;

    // request data sits in the low bytes, lsb first
    typedef struct packed {
        vAddrT    vAddr;
        accSizeT  size;
        logic     write;
        lineDataT data;
    } memReqT;

    // one access to one physical line, data already in line position
    typedef struct packed {
        lineIdxT  line;
        logic     write;
        byteMaskT mask;
        lineDataT data;
    } lineAccT;

endpackage

//--- memAlignTb.sv
module memAlignTb;
    timeunit 1ns;
    timeprecision 100ps;
    import memAlignPkg::*;

    localparam int   DEPTH       = 8;
    localparam int   LINES       = 16;
    localparam int   BURST       = 24;
    localparam int   STALL_LIMIT = 100;
    localparam int   RSP_LIMIT   = 300;
    localparam vpnT  PAGE_A      = 20'h00010;
    localparam vpnT  PAGE_B      = 20'h00011;
    localparam vpnT  PAGE_RO     = 20'h00020;
    localparam pfnT  PFN_A       = 3'd1;
    localparam pfnT  PFN_B       = 3'd2;
    localparam pfnT  PFN_RO      = 3'd5;

    logic       clk;
    logic       rstN;
    logic       reqValid;
    memReqT     req;
    logic       tlbFill;
    logic [2:0] tlbFillIdx;
    tlbEntryT   tlbFillEntry;
    logic       reqStall;
    logic       fault;
    logic       faultMiss;
    logic       faultProt;
    logic       rspValid;
    lineIdxT    rspLine;
    byteMaskT   rspMask;
    lineDataT   rspData;

    // reference line memory and expected / received read responses
    lineDataT   refLines [LINES];
    lineIdxT    expLine [$];
    byteMaskT   expMask [$];
    lineDataT   expData [$];
    lineIdxT    gotLine [$];
    byteMaskT   gotMask [$];
    lineDataT   gotData [$];
    int         faultCnt;
    int         faultsExpected;
    logic       lastMiss;
    logic       lastProt;
    // modeled queue level and the entries due at the next edge
    int         qModel;
    int         pushNext;
    int         errors;
    int         checks;
    vAddrT      burstAddr [BURST];
    accSizeT    burstSize [BURST];

    memAlignTop #(.DEPTH(DEPTH), .LINES(LINES)) dut (
        .clk          (clk),
        .rstN         (rstN),
        .reqValid     (reqValid),
        .req          (req),
        .tlbFill      (tlbFill),
        .tlbFillIdx   (tlbFillIdx),
        .tlbFillEntry (tlbFillEntry),
        .reqStall     (reqStall),
        .fault        (fault),
        .faultMiss    (faultMiss),
        .faultProt    (faultProt),
        .rspValid     (rspValid),
        .rspLine      (rspLine),
        .rspMask      (rspMask),
        .rspData      (rspData)
    );

    always #50 clk = ~clk;

    task automatic checkValue(input string testName, input logic [127:0] expected,
                              input logic [127:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %0h, actual %0h", testName, expected, actual);
        end
    endtask

    function automatic pfnT frameOf(input vpnT vpn);
        case (vpn)
            PAGE_A:  return PFN_A;
            PAGE_B:  return PFN_B;
            PAGE_RO: return PFN_RO;
            default: return '0;
        endcase
    endfunction

    // number of line accesses a request queues, none when it faults
    function automatic int linesQueued(input memReqT r);
        int    o;
        int    n;
        int    cnt;
        vAddrT lineAddr;
        o   = r.vAddr[3:0];
        n   = 1 << r.size;
        cnt = (o + n > LINE_BYTES) ? 2 : 1;
        for (int k = 0; k < cnt; k++) begin
            lineAddr = {r.vAddr[31:4], 4'h0} + vAddrT'(LINE_BYTES * k);
            // unmapped pages have no frame
            if (frameOf(lineAddr[31:12]) == '0) begin
                return 0;
            end
            if (r.write && (lineAddr[31:12] == PAGE_RO)) begin
                return 0;
            end
        end
        return cnt;
    endfunction

    // collect responses and faults as they leave the DUT, track the queue level
    always @(posedge clk) begin
        checkValue("stall", qModel > DEPTH - 4, reqStall);
        if (rspValid) begin
            gotLine.push_back(rspLine);
            gotMask.push_back(rspMask);
            gotData.push_back(rspData);
        end
        if (fault) begin
            faultCnt++;
            lastMiss = faultMiss;
            lastProt = faultProt;
        end
        qModel   = qModel + pushNext - ((qModel > 0) ? 1 : 0);
        pushNext = reqValid ? linesQueued(req) : 0;
    end

    function automatic lineDataT randLine();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // a request sent now is seen with the stall level after the coming edge
    function automatic bit sendBlocked();
        int nextCount;
        nextCount = qModel + pushNext - ((qModel > 0) ? 1 : 0);
        return reqStall || (nextCount > DEPTH - 4);
    endfunction

    // byte i of the request lands at line position o + i, spilling into the next line
    task automatic modelAccess(input vAddrT addr, input accSizeT size, input logic write,
                               input lineDataT data);
        int       o;
        int       n;
        int       nLines;
        int       pos;
        vAddrT    lineAddr;
        lineIdxT  pLine;
        byteMaskT mask;
        lineDataT placed;
        lineDataT bits;
        o      = addr[3:0];
        n      = 1 << size;
        nLines = (o + n > LINE_BYTES) ? 2 : 1;
        for (int k = 0; k < nLines; k++) begin
            lineAddr = {addr[31:4], 4'h0} + vAddrT'(LINE_BYTES * k);
            pLine    = {frameOf(lineAddr[31:12]), lineAddr[11:4]};
            mask     = '0;
            placed   = '0;
            for (int i = 0; i < n; i++) begin
                pos = o + i - LINE_BYTES * k;
                if (pos >= 0 && pos < LINE_BYTES) begin
                    mask[pos]           = 1'b1;
                    placed[8*pos +: 8]  = data[8*i +: 8];
                end
            end
            for (int j = 0; j < LINE_BYTES; j++) begin
                bits[8*j +: 8] = {8{mask[j]}};
            end
            if (write) begin
                refLines[pLine % LINES] = (refLines[pLine % LINES] & ~bits) | (placed & bits);
            end else begin
                expLine.push_back(pLine);
                expMask.push_back(mask);
                expData.push_back(refLines[pLine % LINES] & bits);
            end
        end
    endtask

    task automatic issueReq(input vAddrT addr, input accSizeT size, input logic write,
                            input lineDataT data);
        int waitCnt;
        waitCnt = 0;
        @(negedge clk);
        while (sendBlocked() && waitCnt < STALL_LIMIT) begin
            @(posedge clk);
            reqValid <= 1'b0;
            @(negedge clk);
            waitCnt++;
        end
        if (sendBlocked()) begin
            errors++;
            $display("timeout: stall did not release within %0d cycles", STALL_LIMIT);
        end else begin
            @(posedge clk);
            reqValid <= 1'b1;
            req      <= '{vAddr: addr, size: size, write: write, data: data};
        end
    endtask

    task automatic request(input vAddrT addr, input accSizeT size, input logic write,
                           input lineDataT data);
        issueReq(addr, size, write, data);
        modelAccess(addr, size, write, data);
    endtask

    task automatic idleBus();
        @(posedge clk);
        reqValid <= 1'b0;
    endtask

    task automatic fillTlb(input logic [2:0] idx, input vpnT vpn, input pfnT pfn,
                           input logic writable);
        @(posedge clk);
        tlbFill      <= 1'b1;
        tlbFillIdx   <= idx;
        tlbFillEntry <= '{vpn: vpn, pfn: pfn, valid: 1'b1, writable: writable};
        @(posedge clk);
        tlbFill      <= 1'b0;
    endtask

    task automatic checkResponses(input string testName);
        int waitCnt;
        idleBus();
        waitCnt = 0;
        @(negedge clk);
        while (gotLine.size() < expLine.size() && waitCnt < RSP_LIMIT) begin
            @(negedge clk);
            waitCnt++;
        end
        if (gotLine.size() < expLine.size()) begin
            errors++;
            $display("timeout: %s received %0d of %0d read responses", testName,
                     gotLine.size(), expLine.size());
        end
        // a stray extra response would arrive within these cycles
        repeat (4) @(negedge clk);
        checkValue({testName, " count"}, expLine.size(), gotLine.size());
        while (expLine.size() > 0 && gotLine.size() > 0) begin
            checkValue({testName, " line"}, expLine.pop_front(), gotLine.pop_front());
            checkValue({testName, " mask"}, expMask.pop_front(), gotMask.pop_front());
            checkValue({testName, " data"}, expData.pop_front(), gotData.pop_front());
        end
        expLine.delete();
        expMask.delete();
        expData.delete();
        gotLine.delete();
        gotMask.delete();
        gotData.delete();
    endtask

    task automatic checkFault(input string testName, input logic expMiss,
                              input logic expProt);
        int waitCnt;
        idleBus();
        waitCnt = 0;
        @(negedge clk);
        while (faultCnt <= faultsExpected && waitCnt < 20) begin
            @(negedge clk);
            waitCnt++;
        end
        if (faultCnt <= faultsExpected) begin
            errors++;
            $display("timeout: %s raised no fault", testName);
        end else begin
            checkValue({testName, " faultMiss"}, expMiss, lastMiss);
            checkValue({testName, " faultProt"}, expProt, lastProt);
        end
        faultsExpected++;
    endtask

    task automatic alignedTest();
        vAddrT addrs [4];
        addrs = '{32'h0001_0000, 32'h0001_0012, 32'h0001_0024, 32'h0001_0038};
        for (int s = 0; s < 4; s++) begin
            request(addrs[s], accSizeT'(s), 1'b1, randLine());
        end
        for (int s = 0; s < 4; s++) begin
            request(addrs[s], accSizeT'(s), 1'b0, '0);
        end
        checkResponses("aligned");
    endtask

    task automatic crossTest();
        request(32'h0001_004C, SIZE_B8, 1'b1, randLine());
        // this one also crosses into the next page
        request(32'h0001_0FFC, SIZE_B8, 1'b1, randLine());
        request(32'h0001_004C, SIZE_B8, 1'b0, '0);
        request(32'h0001_0FFC, SIZE_B8, 1'b0, '0);
        checkResponses("lineCross");
    endtask

    task automatic missTest();
        issueReq(32'h0003_0004, SIZE_B4, 1'b1, randLine());
        checkFault("tlbMiss", 1'b1, 1'b0);
        // first line hits, the following page is unmapped
        issueReq(32'h0001_1FFC, SIZE_B8, 1'b1, randLine());
        checkFault("tlbMissNext", 1'b1, 1'b0);
        issueReq(32'h0003_0000, SIZE_B1, 1'b0, '0);
        checkFault("tlbMissRead", 1'b1, 1'b0);
        request(32'h0001_0000, SIZE_B8, 1'b0, '0);
        request(32'h0001_1FF8, SIZE_B8, 1'b0, '0);
        checkResponses("tlbMiss");
    endtask

    task automatic protTest();
        issueReq(32'h0002_0008, SIZE_B8, 1'b1, randLine());
        checkFault("protect", 1'b0, 1'b1);
        request(32'h0002_0008, SIZE_B8, 1'b0, '0);
        checkResponses("protect");
    endtask

    task automatic burstTest();
        for (int i = 0; i < BURST; i++) begin
            burstAddr[i] = 32'h0001_0000 + ($urandom() % 32'h1FF0);
            burstSize[i] = accSizeT'($urandom() % 4);
            request(burstAddr[i], burstSize[i], 1'b1, randLine());
        end
        for (int i = 0; i < BURST; i++) begin
            request(burstAddr[i], burstSize[i], 1'b0, '0);
        end
        checkResponses("burst");
    endtask

    initial begin
        void'($urandom(96243));
        clk            = 1'b0;
        rstN           = 1'b0;
        reqValid       = 1'b0;
        req            = '0;
        tlbFill        = 1'b0;
        tlbFillIdx     = '0;
        tlbFillEntry   = '0;
        errors         = 0;
        checks         = 0;
        faultCnt       = 0;
        faultsExpected = 0;
        lastMiss       = 1'b0;
        lastProt       = 1'b0;
        qModel         = 0;
        pushNext       = 0;
        for (int i = 0; i < LINES; i++) begin
            refLines[i] = '0;
        end
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        fillTlb(3'd0, PAGE_A, PFN_A, 1'b1);
        fillTlb(3'd1, PAGE_B, PFN_B, 1'b1);
        fillTlb(3'd2, PAGE_RO, PFN_RO, 1'b0);
        alignedTest();
        crossTest();
        missTest();
        protTest();
        burstTest();
        checkValue("faultCount", faultsExpected, faultCnt);
        errors += dut.protocolChecks.assertFails;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 dut.protocolChecks.assertFails);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- memAlignTb_asserts.sv
module memAlignAsserts (
    input logic clk,
    input logic rstN,
    input logic reqValid,
    input logic reqStall,
    input logic fault,
    input logic accValid0,
    input logic accValid1
);
    timeunit 1ns;
    timeprecision 100ps;

    // read by the testbench summary
    int assertFails = 0;

    // source holds off while the queue is nearly full
    noReqWhenStalled: assert property (@(posedge clk) disable iff (!rstN)
        !(reqValid && reqStall))
        else begin
            assertFails++;
            $error("request presented while reqStall is high");
        end

    // a faulting request queues nothing
    faultExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(fault && accValid0))
        else begin
            assertFails++;
            $error("fault and accValid0 high in the same cycle");
        end

    secondNeedsFirst: assert property (@(posedge clk) disable iff (!rstN)
        accValid1 |-> accValid0)
        else begin
            assertFails++;
            $error("accValid1 high without accValid0");
        end

endmodule

bind memAlignTop memAlignAsserts protocolChecks (
    .clk       (clk),
    .rstN      (rstN),
    .reqValid  (reqValid),
    .reqStall  (reqStall),
    .fault     (fault),
    .accValid0 (accValid0),
    .accValid1 (accValid1)
);

//--- memAlignTop.sv
module memAlignTop #(
    parameter int DEPTH = 8,
    parameter int LINES = 16
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  reqValid,
    input  memAlignPkg::memReqT   req,
    input  logic                  tlbFill,
    input  logic [2:0]            tlbFillIdx,
    input  memAlignPkg::tlbEntryT tlbFillEntry,
    output logic                  reqStall,
    output logic                  fault,
    output logic                  faultMiss,
    output logic                  faultProt,
    output logic                  rspValid,
    output memAlignPkg::lineIdxT  rspLine,
    output memAlignPkg::byteMaskT rspMask,
    output memAlignPkg::lineDataT rspData
);
    import memAlignPkg::*;

    lineAccT acc0;
    lineAccT acc1;
    logic    accValid0;
    logic    accValid1;
    lineAccT qHead;
    logic    qEmpty;
    logic    qPop;

    accessAlign aligner (
        .clk       (clk),
        .rstN      (rstN),
        .reqValid  (reqValid),
        .req       (req),
        .fill      (tlbFill),
        .fillIdx   (tlbFillIdx),
        .fillEntry (tlbFillEntry),
        .acc0      (acc0),
        .acc1      (acc1),
        .accValid0 (accValid0),
        .accValid1 (accValid1),
        .fault     (fault),
        .faultMiss (faultMiss),
        .faultProt (faultProt)
    );

    // stall comes straight from the queue fill level
    lineQueue #(.DEPTH(DEPTH)) queue (
        .clk        (clk),
        .rstN       (rstN),
        .push0      (accValid0),
        .push1      (accValid1),
        .in0        (acc0),
        .in1        (acc1),
        .pop        (qPop),
        .head       (qHead),
        .empty      (qEmpty),
        .almostFull (reqStall)
    );

    lineStore #(.LINES(LINES)) store (
        .clk      (clk),
        .rstN     (rstN),
        .empty    (qEmpty),
        .head     (qHead),
        .pop      (qPop),
        .rspValid (rspValid),
        .rspLine  (rspLine),
        .rspMask  (rspMask),
        .rspData  (rspData)
    );

endmodule

//--- tlbLookup.sv
module tlbLookup (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  fill,
    input  logic [2:0]            fillIdx,
    input  memAlignPkg::tlbEntryT fillEntry,
    input  memAlignPkg::vpnT      vpn,
    input  logic                  write,
    output memAlignPkg::pfnT      pfn,
    output logic                  miss,
    output logic                  prot
);
    import memAlignPkg::*;

    tlbEntryT entries [TLB_ENTRIES];
    logic     hit;
    logic     hitWritable;

    // entries come up invalid
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (fill) begin
            entries[fillIdx] <= fillEntry;
        end
    end

    // scan from the top so the lowest matching index wins
    always_comb begin
        hit         = 1'b0;
        hitWritable = 1'b0;
        pfn         = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entries[i].valid && (entries[i].vpn == vpn)) begin
                hit         = 1'b1;
                hitWritable = entries[i].writable;
                pfn         = entries[i].pfn;
            end
        end
    end

    assign miss = !hit;
    // only a write to a present, read-only page is a protection fault
    assign prot = hit && write && !hitWritable;

endmodule
